//--- rtl/cmd_pkg.sv
package cmd_pkg;

  // ************************************************************
  // widths and frame layout
  // ************************************************************
  localparam int MAC_BYTES = 6;           // bytes per mac address
  localparam int HDR_BYTES = 14;          // dest + src + ethertype
  localparam int CMD_BYTES = 8;           // one command on the wire
  localparam int CMD_BITS  = CMD_BYTES * 8;

  typedef logic [MAC_BYTES*8-1:0] mac_addr_t;

  // command word, first byte on the wire sits in the top byte
  //   [63:56] opcode
  //   [55:48] register address
  //   [47:32] reserved
  //   [31:0]  data, msb first
  typedef logic [CMD_BITS-1:0] cmd_word_t;

  // receive decode enable is bit 5, everything else off
  localparam logic [7:0] ETH_CTRL_RESET = 8'h20;

  // ************************************************************
  // enums
  // ************************************************************
  typedef enum logic [7:0] {
    OP_NOP      = 8'h00,  // accepted, nothing written
    OP_WR_CHIRP = 8'h01,  // chirp param at addr[1:0]
    OP_WR_CTRL  = 8'h02   // addr 0 fmc150, addr 1 ethernet
  } opcode_e;

  typedef enum logic [1:0] {
    ST_HDR     = 2'd0,    // walking dest/src/type
    ST_PAYLOAD = 2'd1,    // addresses matched, forward bytes
    ST_DROP    = 2'd2     // wrong address, swallow until tlast
  } filter_state_e;

endpackage

//--- rtl/frame_filter.sv
`timescale 1ns/10ps

module frame_filter import cmd_pkg::*; #(
  parameter mac_addr_t DEST_ADDR = '0,
  parameter mac_addr_t SRC_ADDR  = '0
) (
  input  logic       gtx_clk_bufg,
  input  logic       gtx_resetn,
  input  logic [7:0] rx_axis_tdata,
  input  logic       rx_axis_tvalid,
  input  logic       rx_axis_tlast,
  output logic       rx_axis_tready,
  output logic [7:0] pay_byte,
  output logic       pay_valid,
  output logic       pay_last,
  input  logic       pay_ready
);

  // both addresses in wire order, dest first, msb byte first
  localparam logic [2*MAC_BYTES*8-1:0] ADDR_REF = {DEST_ADDR, SRC_ADDR};

  filter_state_e state;
  logic [3:0]    hdr_cnt;       // 0..13 while in the header
  logic [7:0]    exp_byte;      // expected address byte at hdr_cnt
  logic          rx_fire;
  logic          addr_miss;

  // credits are the packer's business, just pass its ready upstream
  assign rx_axis_tready = pay_ready;
  assign rx_fire        = rx_axis_tvalid & rx_axis_tready;

  // pick the reference byte for the current header position
  always_comb begin
    exp_byte = 8'h00;
    for (int i = 0; i < 2*MAC_BYTES; i++) begin
      if (hdr_cnt == i) exp_byte = ADDR_REF[8*(2*MAC_BYTES-1-i) +: 8];
    end
  end

  // ethertype bytes are not checked
  assign addr_miss = (hdr_cnt < 2*MAC_BYTES) && (rx_axis_tdata != exp_byte);

  // ************************************************************
  // header walk
  // ************************************************************
  always_ff @(posedge gtx_clk_bufg) begin
    if (!gtx_resetn) begin
      state   <= ST_HDR;
      hdr_cnt <= '0;
    end else if (rx_fire) begin
      if (rx_axis_tlast) begin        // any state, next byte starts a frame
        state   <= ST_HDR;
        hdr_cnt <= '0;
      end else begin
        case (state)
          ST_HDR: begin
            hdr_cnt <= hdr_cnt + 4'd1;
            if (addr_miss)
              state <= ST_DROP;
            else if (hdr_cnt == HDR_BYTES-1)
              state <= ST_PAYLOAD;      // last type byte
          end
          ST_PAYLOAD: state <= ST_PAYLOAD;
          default:    state <= ST_DROP; // hold until tlast
        endcase
      end
    end
  end

  // ************************************************************
  // payload register, one cycle behind the rx port
  // ************************************************************
  always_ff @(posedge gtx_clk_bufg) begin
    if (!gtx_resetn) begin
      pay_valid <= 1'b0;
      pay_last  <= 1'b0;
    end else begin
      pay_valid <= rx_fire && (state == ST_PAYLOAD);
      pay_last  <= rx_fire && (state == ST_PAYLOAD) && rx_axis_tlast;
    end
  end

  always_ff @(posedge gtx_clk_bufg) begin
    if (rx_fire) pay_byte <= rx_axis_tdata;   // data only, no reset
  end

endmodule

//--- rtl/cmd_packer.sv
`timescale 1ns/10ps

module cmd_packer import cmd_pkg::*; #(
  parameter int CMD_CREDITS = 4
) (
  input  logic       gtx_clk_bufg,
  input  logic       gtx_resetn,
  input  logic [7:0] pay_byte,
  input  logic       pay_valid,
  input  logic       pay_last,
  output logic       pay_ready,
  output cmd_word_t  cmd_word,
  output logic       cmd_push,
  input  logic       credit_ret
);

  localparam int CW = $clog2(CMD_CREDITS+1);
  localparam int IW = $clog2(CMD_BYTES);

  logic [CW-1:0] credits;       // free slots in the queue
  logic [IW-1:0] byte_idx;      // position inside current command
  logic          cmd_full;

  assign cmd_full  = pay_valid && (byte_idx == IW'(CMD_BYTES-1));
  assign pay_ready = (credits != '0);   // filter stalls the mac on zero

  // shift in msb first, the word is complete while cmd_push is high
  always_ff @(posedge gtx_clk_bufg) begin
    if (pay_valid) cmd_word <= {cmd_word[CMD_BITS-9:0], pay_byte};
  end

  always_ff @(posedge gtx_clk_bufg) begin
    if (!gtx_resetn) begin
      byte_idx <= '0;
      cmd_push <= 1'b0;
    end else begin
      cmd_push <= cmd_full;
      if (pay_valid) begin
        if (pay_last || cmd_full)
          byte_idx <= '0;             // partial tail is dropped here
        else
          byte_idx <= byte_idx + 1'b1;
      end
    end
  end

  // ************************************************************
  // credit counter, spent as the queue takes the push
  // ************************************************************
  always_ff @(posedge gtx_clk_bufg) begin
    if (!gtx_resetn) begin
      credits <= CW'(CMD_CREDITS);    // queue empty, all credits home
    end else begin
      case ({cmd_push, credit_ret})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // both or neither, net zero
      endcase
    end
  end

endmodule

//--- rtl/cmd_queue.sv
`timescale 1ns/10ps

module cmd_queue import cmd_pkg::*; #(
  parameter int CMD_CREDITS = 4
) (
  input  logic      gtx_clk_bufg,
  input  logic      gtx_resetn,
  input  cmd_word_t cmd_word,
  input  logic      cmd_push,
  output cmd_word_t q_word,
  output logic      q_valid,
  input  logic      q_pop,
  output logic      credit_ret
);

  localparam int PW = (CMD_CREDITS > 1) ? $clog2(CMD_CREDITS) : 1;
  localparam int CW = $clog2(CMD_CREDITS+1);

  cmd_word_t     mem [CMD_CREDITS];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;        // occupancy
  logic          pop_ok;

  assign q_valid    = (count != '0);
  assign q_word     = mem[rd_ptr];       // head, visible the cycle after push
  assign pop_ok     = q_pop & q_valid;
  assign credit_ret = pop_ok;            // one credit per popped word

  // no full check, the packer's credits keep pushes within depth
  always_ff @(posedge gtx_clk_bufg) begin
    if (cmd_push) mem[wr_ptr] <= cmd_word;
  end

  always_ff @(posedge gtx_clk_bufg) begin
    if (!gtx_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (cmd_push)
        wr_ptr <= (wr_ptr == PW'(CMD_CREDITS-1)) ? '0 : wr_ptr + 1'b1;
      if (pop_ok)
        rd_ptr <= (rd_ptr == PW'(CMD_CREDITS-1)) ? '0 : rd_ptr + 1'b1;
      case ({cmd_push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/cmd_executor.sv
`timescale 1ns/10ps

module cmd_executor import cmd_pkg::*; (
  input  logic        gtx_clk_bufg,
  input  logic        gtx_resetn,
  input  cmd_word_t   q_word,
  input  logic        q_valid,
  output logic        q_pop,
  input  logic [7:0]  gpio_dip_sw,
  output logic [31:0] chirp_control_word,
  output logic [31:0] chirp_freq_offset,
  output logic [31:0] chirp_tuning_word_coeff,
  output logic [31:0] chirp_count_max,
  output logic [7:0]  fmc150_ctrl_bus,
  output logic [7:0]  ethernet_ctrl_bus,
  output logic [7:0]  gpio_led,
  output logic        decode_err
);

  opcode_e     opcode;
  logic [7:0]  reg_addr;
  logic [31:0] reg_data;
  logic [3:0]  cmd_cnt;          // executed good commands, wraps
  logic [3:0]  err_cnt;          // bad opcodes, wraps

  // field split of the head word
  assign opcode   = opcode_e'(q_word[63:56]);
  assign reg_addr = q_word[55:48];
  assign reg_data = q_word[31:0];

  assign q_pop    = q_valid & ~gpio_dip_sw[7];   // sw7 on freezes the queue
  assign gpio_led = {err_cnt, cmd_cnt};

  // ************************************************************
  // decode and register bank
  // ************************************************************
  always_ff @(posedge gtx_clk_bufg) begin
    if (!gtx_resetn) begin
      chirp_control_word      <= '0;
      chirp_freq_offset       <= '0;
      chirp_tuning_word_coeff <= '0;
      chirp_count_max         <= '0;
      fmc150_ctrl_bus         <= '0;
      ethernet_ctrl_bus       <= ETH_CTRL_RESET;
      cmd_cnt                 <= '0;
      err_cnt                 <= '0;
      decode_err              <= 1'b0;
    end else begin
      decode_err <= 1'b0;        // single cycle pulse
      if (q_pop) begin
        case (opcode)
          OP_NOP: cmd_cnt <= cmd_cnt + 4'd1;
          OP_WR_CHIRP: begin
            cmd_cnt <= cmd_cnt + 4'd1;
            case (reg_addr[1:0])
              2'd0: chirp_control_word      <= reg_data;
              2'd1: chirp_freq_offset       <= reg_data;
              2'd2: chirp_tuning_word_coeff <= reg_data;
              2'd3: chirp_count_max         <= reg_data;
            endcase
          end
          OP_WR_CTRL: begin
            cmd_cnt <= cmd_cnt + 4'd1;   // counts even for an unused addr
            if (reg_addr == 8'd0) fmc150_ctrl_bus   <= reg_data[7:0];
            if (reg_addr == 8'd1) ethernet_ctrl_bus <= reg_data[7:0];
          end
          default: begin
            // unknown opcode, bank untouched
            decode_err <= 1'b1;
            err_cnt    <= err_cnt + 4'd1;
          end
        endcase
      end
    end
  end

endmodule

//--- rtl/cmd_decoder_top.sv
`timescale 1ns/10ps

module cmd_decoder_top import cmd_pkg::*; #(
  parameter mac_addr_t DEST_ADDR   = 48'h985aebdb066f,
  parameter mac_addr_t SRC_ADDR    = 48'h5a0102030405,
  parameter int        CMD_CREDITS = 4
) (
  input  logic        gtx_clk_bufg,
  input  logic        gtx_resetn,

  // receive byte stream from the mac
  input  logic [7:0]  rx_axis_tdata,
  input  logic        rx_axis_tvalid,
  input  logic        rx_axis_tlast,
  output logic        rx_axis_tready,

  input  logic [7:0]  gpio_dip_sw,   // sw7 pauses execution

  // register bank
  output logic [31:0] chirp_control_word,
  output logic [31:0] chirp_freq_offset,
  output logic [31:0] chirp_tuning_word_coeff,
  output logic [31:0] chirp_count_max,
  output logic [7:0]  fmc150_ctrl_bus,
  output logic [7:0]  ethernet_ctrl_bus,
  output logic [7:0]  gpio_led,      // {err count, cmd count}
  output logic        decode_err
);

  // filter -> packer
  logic [7:0] pay_byte;
  logic       pay_valid;
  logic       pay_last;
  logic       pay_ready;      // packer holds a credit

  // packer -> queue, credits come back
  cmd_word_t  cmd_word;
  logic       cmd_push;
  logic       credit_ret;

  // queue -> executor
  cmd_word_t  q_word;
  logic       q_valid;
  logic       q_pop;

  frame_filter #(
    .DEST_ADDR (DEST_ADDR),
    .SRC_ADDR  (SRC_ADDR)
  ) frame_filter_inst (
    .gtx_clk_bufg   (gtx_clk_bufg),
    .gtx_resetn     (gtx_resetn),
    .rx_axis_tdata  (rx_axis_tdata),
    .rx_axis_tvalid (rx_axis_tvalid),
    .rx_axis_tlast  (rx_axis_tlast),
    .rx_axis_tready (rx_axis_tready),
    .pay_byte       (pay_byte),
    .pay_valid      (pay_valid),
    .pay_last       (pay_last),
    .pay_ready      (pay_ready)
  );

  cmd_packer #(
    .CMD_CREDITS (CMD_CREDITS)
  ) cmd_packer_inst (
    .gtx_clk_bufg (gtx_clk_bufg),
    .gtx_resetn   (gtx_resetn),
    .pay_byte     (pay_byte),
    .pay_valid    (pay_valid),
    .pay_last     (pay_last),
    .pay_ready    (pay_ready),
    .cmd_word     (cmd_word),
    .cmd_push     (cmd_push),
    .credit_ret   (credit_ret)
  );

  cmd_queue #(
    .CMD_CREDITS (CMD_CREDITS)    // depth == credits, never overflows
  ) cmd_queue_inst (
    .gtx_clk_bufg (gtx_clk_bufg),
    .gtx_resetn   (gtx_resetn),
    .cmd_word     (cmd_word),
    .cmd_push     (cmd_push),
    .q_word       (q_word),
    .q_valid      (q_valid),
    .q_pop        (q_pop),
    .credit_ret   (credit_ret)
  );

  cmd_executor cmd_executor_inst (
    .gtx_clk_bufg            (gtx_clk_bufg),
    .gtx_resetn              (gtx_resetn),
    .q_word                  (q_word),
    .q_valid                 (q_valid),
    .q_pop                   (q_pop),
    .gpio_dip_sw             (gpio_dip_sw),
    .chirp_control_word      (chirp_control_word),
    .chirp_freq_offset       (chirp_freq_offset),
    .chirp_tuning_word_coeff (chirp_tuning_word_coeff),
    .chirp_count_max         (chirp_count_max),
    .fmc150_ctrl_bus         (fmc150_ctrl_bus),
    .ethernet_ctrl_bus       (ethernet_ctrl_bus),
    .gpio_led                (gpio_led),
    .decode_err              (decode_err)
  );

endmodule

//--- dv/cmd_decoder_asserts.sv
`timescale 1ns/10ps

// generic level checker, bound once on the packer credits and once on the queue free slots
module cmd_decoder_asserts #(
  parameter int LIMIT = 4,              // credits at reset == queue depth
  parameter int W     = 3
) (
  input logic         gtx_clk_bufg,
  input logic         gtx_resetn,
  input logic [W-1:0] level,            // credit count or free queue slots
  input logic         take              // event that uses up one unit
);

  int fail_cnt = 0;                     // read by the testbench at the end

  // level stays within the configured limit
  a_level_max: assert property (@(posedge gtx_clk_bufg) disable iff (!gtx_resetn)
    level <= W'(LIMIT))
  else begin
    $error("level %0d above limit %0d", level, LIMIT);
    fail_cnt <= fail_cnt + 1;
  end

  // a push needs a credit in the packer and a free slot in the queue
  a_take_nonzero: assert property (@(posedge gtx_clk_bufg) disable iff (!gtx_resetn)
    take |-> (level != '0))
  else begin
    $error("unit taken while level is zero");
    fail_cnt <= fail_cnt + 1;
  end

endmodule

bind cmd_packer cmd_decoder_asserts #(.LIMIT(CMD_CREDITS), .W(CW)) packer_asserts (
  .gtx_clk_bufg (gtx_clk_bufg),
  .gtx_resetn   (gtx_resetn),
  .level        (credits),
  .take         (cmd_push)
);

// free slots wrap above depth when occupancy overruns or underruns
bind cmd_queue cmd_decoder_asserts #(.LIMIT(CMD_CREDITS), .W(CW)) queue_asserts (
  .gtx_clk_bufg (gtx_clk_bufg),
  .gtx_resetn   (gtx_resetn),
  .level        (CW'(CMD_CREDITS) - count),
  .take         (cmd_push)
);

//--- dv/tb_cmd_decoder.sv
`timescale 1ns/10ps

module tb_cmd_decoder import cmd_pkg::*; ();

  localparam mac_addr_t DEST        = 48'h02005e10a3c7;
  localparam mac_addr_t SRC         = 48'h001b21c4f0e9;
  localparam int        CREDITS     = 4;
  localparam int        CLK_NS      = 40;
  localparam int        RST_CYCLES  = 16;
  localparam int        N_FRAMES    = 60;
  localparam int        WATCHDOG_NS = N_FRAMES * 80 * CLK_NS * 4;  // 80 bytes per frame, x4 slack

  logic        gtx_clk_bufg;
  logic        gtx_resetn;
  logic [7:0]  rx_axis_tdata;
  logic        rx_axis_tvalid;
  logic        rx_axis_tlast;
  logic        rx_axis_tready;
  logic [7:0]  gpio_dip_sw;
  logic [31:0] chirp_control_word;
  logic [31:0] chirp_freq_offset;
  logic [31:0] chirp_tuning_word_coeff;
  logic [31:0] chirp_count_max;
  logic [7:0]  fmc150_ctrl_bus;
  logic [7:0]  ethernet_ctrl_bus;
  logic [7:0]  gpio_led;
  logic        decode_err;

  // reference model state
  logic [31:0] exp_chirp [4];
  logic [7:0]  exp_fmc;
  logic [7:0]  exp_eth;
  logic [3:0]  exp_cmd_cnt;             // low nibble of gpio_led
  logic [3:0]  exp_err_cnt;             // high nibble
  int          exp_err_pulses = 0;
  int          seen_err_pulses = 0;
  integer      seed;
  logic        saw_stall = 1'b0;        // tready fell at least once
  int          stall_cnt;

  cmd_decoder_top #(
    .DEST_ADDR   (DEST),
    .SRC_ADDR    (SRC),
    .CMD_CREDITS (CREDITS)
  ) dut_i (
    .gtx_clk_bufg            (gtx_clk_bufg),
    .gtx_resetn              (gtx_resetn),
    .rx_axis_tdata           (rx_axis_tdata),
    .rx_axis_tvalid          (rx_axis_tvalid),
    .rx_axis_tlast           (rx_axis_tlast),
    .rx_axis_tready          (rx_axis_tready),
    .gpio_dip_sw             (gpio_dip_sw),
    .chirp_control_word      (chirp_control_word),
    .chirp_freq_offset       (chirp_freq_offset),
    .chirp_tuning_word_coeff (chirp_tuning_word_coeff),
    .chirp_count_max         (chirp_count_max),
    .fmc150_ctrl_bus         (fmc150_ctrl_bus),
    .ethernet_ctrl_bus       (ethernet_ctrl_bus),
    .gpio_led                (gpio_led),
    .decode_err              (decode_err)
  );

  initial begin
    gtx_clk_bufg = 1'b0;
    forever #(CLK_NS/2) gtx_clk_bufg = ~gtx_clk_bufg;
  end

  // sampled before the edge's updates, one count per pulse
  always @(posedge gtx_clk_bufg) begin
    if (gtx_resetn && decode_err) seen_err_pulses++;
  end

  initial begin
    #(RST_CYCLES * CLK_NS + WATCHDOG_NS);
    $display("timeout: the DUT stopped taking bytes or never drained its queue");
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_outputs();
    check_value("chirp_control_word", chirp_control_word, exp_chirp[0]);
    check_value("chirp_freq_offset", chirp_freq_offset, exp_chirp[1]);
    check_value("chirp_tuning_word_coeff", chirp_tuning_word_coeff, exp_chirp[2]);
    check_value("chirp_count_max", chirp_count_max, exp_chirp[3]);
    check_value("fmc150_ctrl_bus", fmc150_ctrl_bus, exp_fmc);
    check_value("ethernet_ctrl_bus", ethernet_ctrl_bus, exp_eth);
    check_value("gpio_led", gpio_led, {exp_err_cnt, exp_cmd_cnt});
    check_value("decode_err pulses", seen_err_pulses, exp_err_pulses);
  endtask

  // ************************************************************
  // reference model, one command at a time
  // ************************************************************
  task automatic exec_cmd(input logic [7:0] op, input logic [7:0] addr, input logic [31:0] data);
    case (op)
      OP_NOP:      exp_cmd_cnt++;
      OP_WR_CHIRP: begin
        exp_cmd_cnt++;
        exp_chirp[addr[1:0]] = data;
      end
      OP_WR_CTRL:  begin
        exp_cmd_cnt++;                      // counted even when addr is unused
        if (addr == 8'd0) exp_fmc = data[7:0];
        if (addr == 8'd1) exp_eth = data[7:0];
      end
      default: begin
        exp_err_cnt++;
        exp_err_pulses++;
      end
    endcase
  endtask

  // byte held until the DUT takes it, sw7 dropped after a long stall
  task automatic send_byte(input logic [7:0] b, input logic last);
    rx_axis_tdata  <= b;
    rx_axis_tvalid <= 1'b1;
    rx_axis_tlast  <= last;
    do begin
      @(posedge gtx_clk_bufg);
      if (!rx_axis_tready) begin
        saw_stall = 1'b1;
        stall_cnt++;
        if (stall_cnt == 8) gpio_dip_sw[7] <= 1'b0;
      end
    end while (!rx_axis_tready);
  endtask

  task automatic run_frame(input int f);
    logic [7:0]  bytes [$];
    logic [7:0]  cmd [8];
    logic [47:0] d;
    logic [47:0] s;
    logic        pause;
    int          ncmd;
    int          tail;
    int          miss;
    int          k;
    pause = (($random(seed) & 3) == 0) || (f % 10 == 3);
    ncmd  = pause ? 5 + $unsigned($random(seed)) % 3 : 1 + $unsigned($random(seed)) % 7;
    tail  = (($random(seed) & 3) == 0) ? 1 + $unsigned($random(seed)) % 7 : 0;
    miss  = $unsigned($random(seed)) % 8;   // 0 bad dest, 1 bad src, rest match
    k     = $unsigned($random(seed)) % 6;
    d     = DEST;
    s     = SRC;
    if (miss == 0) d[8*k +: 8] = d[8*k +: 8] ^ 8'h10;
    if (miss == 1) s[8*k +: 8] = s[8*k +: 8] ^ 8'h01;
    for (int i = 0; i < 6; i++) bytes.push_back(d[8*(5-i) +: 8]);
    for (int i = 0; i < 6; i++) bytes.push_back(s[8*(5-i) +: 8]);
    bytes.push_back(8'h88);                  // ethertype, not checked
    bytes.push_back(8'($random(seed)));
    for (int c = 0; c < ncmd; c++) begin
      for (int i = 0; i < 8; i++) cmd[i] = 8'($random(seed));
      case ($unsigned($random(seed)) % 6)
        0:       cmd[0] = OP_NOP;
        1, 2:    cmd[0] = OP_WR_CHIRP;
        3:       begin
          cmd[0] = OP_WR_CTRL;
          cmd[1] = cmd[1] & 8'h03;           // 0 fmc150, 1 ethernet, 2-3 ignored
        end
        default: if (cmd[0] <= 8'h02) cmd[0] = cmd[0] | 8'h80;  // unknown opcode
      endcase
      for (int i = 0; i < 8; i++) bytes.push_back(cmd[i]);
      if (miss > 1) exec_cmd(cmd[0], cmd[1], {cmd[4], cmd[5], cmd[6], cmd[7]});
    end
    for (int t = 0; t < tail; t++) bytes.push_back(8'($random(seed)));  // partial command

    gpio_dip_sw <= {pause, 7'($random(seed))};
    stall_cnt = 0;
    foreach (bytes[i]) send_byte(bytes[i], i == bytes.size() - 1);
    rx_axis_tvalid <= 1'b0;
    rx_axis_tlast  <= 1'b0;
    gpio_dip_sw[7] <= 1'b0;

    // let the pipeline fill, then wait until the queue is empty
    repeat (3) @(posedge gtx_clk_bufg);
    while (dut_i.q_valid || dut_i.pay_valid || dut_i.cmd_push) @(posedge gtx_clk_bufg);
    @(negedge gtx_clk_bufg);
    compare_outputs();
    @(posedge gtx_clk_bufg);
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************
  initial begin
    seed           = 32'h2cfbd4d8;
    gtx_resetn     <= 1'b0;
    rx_axis_tdata  <= 8'h00;
    rx_axis_tvalid <= 1'b0;
    rx_axis_tlast  <= 1'b0;
    gpio_dip_sw    <= 8'h00;
    for (int i = 0; i < 4; i++) exp_chirp[i] = '0;
    exp_fmc     = 8'h00;
    exp_eth     = ETH_CTRL_RESET;
    exp_cmd_cnt = 4'd0;
    exp_err_cnt = 4'd0;
    repeat (RST_CYCLES) @(posedge gtx_clk_bufg);
    gtx_resetn <= 1'b1;
    @(posedge gtx_clk_bufg);
    @(negedge gtx_clk_bufg);
    check_value("rx_axis_tready", rx_axis_tready, 32'd1);   // all credits free
    compare_outputs();
    @(posedge gtx_clk_bufg);

    for (int f = 0; f < N_FRAMES; f++) run_frame(f);

    if (!saw_stall || dut_i.cmd_packer_inst.packer_asserts.fail_cnt != 0 ||
        dut_i.cmd_queue_inst.queue_asserts.fail_cnt != 0) begin
      if (!saw_stall)
        $display("rx_axis_tready never fell while command execution was paused");
      else
        $display("credit or queue assertions failed during the run");
      $display("Test FAILED");
      $fatal(1, "run failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

//--- build.f
rtl/cmd_pkg.sv
rtl/frame_filter.sv
rtl/cmd_packer.sv
rtl/cmd_queue.sv
rtl/cmd_executor.sv
rtl/cmd_decoder_top.sv
dv/cmd_decoder_asserts.sv
dv/tb_cmd_decoder.sv
